// File: Makefile
# Verilator build and run of the memory adapter testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_adapter
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_LINE  = STATUS: PASS

SOURCES = $(wildcard hdl/*.sv bench/*.sv bench/*.svh)
SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the bench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_LINE)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_vectors.svh
// stimulus and expected-value rows for the encoder and decoder checks

typedef struct packed {
   mem_command_e rd_cmd;
   mem_atomic_e  rd_op;
   logic         rd_cacheable;
   mem_command_e wr_cmd;
   mem_atomic_e  wr_op;
   logic         wr_cacheable;
   axi_resp_e    r_resp;
   axi_resp_e    b_resp;
   logic         exp_ar_lock;
   logic         exp_aw_lock;
   logic [5:0]   exp_atop;
   logic         exp_rd_err;
   logic         exp_wr_err;
   logic         exp_is_atomic;
} vec_t;

localparam int NUM_VECS = 13;

// columns: rd cmd, op, cacheable | wr cmd, op, cacheable | r resp, b resp |
// expected ar lock, aw lock, atop, read error, write error, is_atomic
localparam vec_t VECS [NUM_VECS] = '{
   '{MEM_READ,   MEM_ATOMIC_ADD,  1'b1, MEM_WRITE,  MEM_ATOMIC_ADD,  1'b0,
     AXI_RESP_OKAY,   AXI_RESP_OKAY,   1'b0, 1'b0, 6'h00, 1'b0, 1'b0, 1'b0},
   '{MEM_ATOMIC, MEM_ATOMIC_LDEX, 1'b0, MEM_ATOMIC, MEM_ATOMIC_ADD,  1'b1,
     AXI_RESP_EXOKAY, AXI_RESP_EXOKAY, 1'b1, 1'b0, 6'h10, 1'b0, 1'b0, 1'b1},
   '{MEM_ATOMIC, MEM_ATOMIC_ADD,  1'b1, MEM_ATOMIC, MEM_ATOMIC_CLR,  1'b0,
     AXI_RESP_SLVERR, AXI_RESP_SLVERR, 1'b0, 1'b0, 6'h11, 1'b1, 1'b1, 1'b0},
   // ldex code without the atomic command gives no lock
   '{MEM_READ,   MEM_ATOMIC_LDEX, 1'b0, MEM_ATOMIC, MEM_ATOMIC_SET,  1'b1,
     AXI_RESP_DECERR, AXI_RESP_DECERR, 1'b0, 1'b0, 6'h12, 1'b1, 1'b1, 1'b0},
   '{MEM_READ,   MEM_ATOMIC_ADD,  1'b1, MEM_ATOMIC, MEM_ATOMIC_EOR,  1'b0,
     AXI_RESP_OKAY,   AXI_RESP_EXOKAY, 1'b0, 1'b0, 6'h13, 1'b0, 1'b0, 1'b1},
   '{MEM_ATOMIC, MEM_ATOMIC_LDEX, 1'b1, MEM_ATOMIC, MEM_ATOMIC_SMAX, 1'b1,
     AXI_RESP_EXOKAY, AXI_RESP_OKAY,   1'b1, 1'b0, 6'h14, 1'b0, 1'b0, 1'b0},
   '{MEM_READ,   MEM_ATOMIC_ADD,  1'b0, MEM_ATOMIC, MEM_ATOMIC_SMIN, 1'b0,
     AXI_RESP_SLVERR, AXI_RESP_DECERR, 1'b0, 1'b0, 6'h15, 1'b1, 1'b1, 1'b0},
   '{MEM_ATOMIC, MEM_ATOMIC_SWAP, 1'b1, MEM_ATOMIC, MEM_ATOMIC_UMAX, 1'b1,
     AXI_RESP_DECERR, AXI_RESP_SLVERR, 1'b0, 1'b0, 6'h16, 1'b1, 1'b1, 1'b0},
   '{MEM_READ,   MEM_ATOMIC_ADD,  1'b0, MEM_ATOMIC, MEM_ATOMIC_UMIN, 1'b0,
     AXI_RESP_OKAY,   AXI_RESP_OKAY,   1'b0, 1'b0, 6'h17, 1'b0, 1'b0, 1'b0},
   '{MEM_ATOMIC, MEM_ATOMIC_LDEX, 1'b0, MEM_ATOMIC, MEM_ATOMIC_SWAP, 1'b1,
     AXI_RESP_EXOKAY, AXI_RESP_EXOKAY, 1'b1, 1'b0, 6'h30, 1'b0, 1'b0, 1'b1},
   '{MEM_READ,   MEM_ATOMIC_ADD,  1'b1, MEM_ATOMIC, MEM_ATOMIC_LDEX, 1'b0,
     AXI_RESP_OKAY,   AXI_RESP_SLVERR, 1'b0, 1'b0, 6'h11, 1'b0, 1'b1, 1'b0},
   '{MEM_READ,   MEM_ATOMIC_ADD,  1'b0, MEM_ATOMIC, MEM_ATOMIC_STEX, 1'b1,
     AXI_RESP_EXOKAY, AXI_RESP_EXOKAY, 1'b0, 1'b1, 6'h12, 1'b0, 1'b0, 1'b1},
   // plain write carrying a stale stex code
   '{MEM_READ,   MEM_ATOMIC_ADD,  1'b1, MEM_WRITE,  MEM_ATOMIC_STEX, 1'b0,
     AXI_RESP_SLVERR, AXI_RESP_OKAY,   1'b0, 1'b0, 6'h00, 1'b1, 1'b0, 1'b0}
};

// File: bench/tb_mem_adapter.sv
// testbench for the memory adapter with table-driven AXI checks and arbiter traffic
`timescale 1ns/10ps

module tb_mem_adapter
   import mem_adapter_pkg::*;
();

   `include "tb_vectors.svh"

   localparam int RAND_CYCLES  = 200;
   localparam int ARB_DIRECTED = 14;
   localparam int RUN_CYCLES   = 5 + 3 * (NUM_VECS + 1) + ARB_DIRECTED + RAND_CYCLES;
   localparam int WATCHDOG_NS  = 4 * RUN_CYCLES * 10;

   logic          clk_i = 1'b0;
   logic          reset_i;
   logic          rd_req_valid_i, wr_req_valid_i, wr_data_valid_i;
   mem_req_t      rd_req_i, wr_req_i;
   mem_req_w_t    wr_data_i;
   logic          rd_req_ready_o, wr_req_ready_o, wr_data_ready_o;
   logic          ar_valid_o, aw_valid_o, w_valid_o;
   axi_ar_t       ar_o;
   axi_aw_t       aw_o;
   axi_w_t        w_o;
   logic          ar_ready_i, aw_ready_i, w_ready_i;
   logic          r_valid_i, b_valid_i, r_ready_o, b_ready_o;
   axi_r_t        r_i;
   axi_b_t        b_i;
   logic          rd_rsp_valid_o, wr_rsp_valid_o;
   mem_resp_r_t   rd_rsp_o;
   mem_resp_w_t   wr_rsp_o;
   logic          rd_rsp_ready_i, wr_rsp_ready_i;
   logic          rd_valid_i, wr_valid_i, rd_ready_o, wr_ready_o;
   mem_port_req_t rd_port_req_i, wr_port_req_i, mem_req_o;
   logic          mem_valid_o, mem_ready_i;

   logic [31:0]   lcg_state;
   logic          ref_prio;
   int            check_count;
   int            fail_count;
   int            test_count;
   int            test_fail_count;
   int            fails_at_start;
   int            accepted;
   string         cur_test;

   mem_adapter_top u_dut (.*);

   always #5 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic check_value(input string name, input logic [127:0] exp,
                              input logic [127:0] act);
      check_count++;
      if (act !== exp) begin
         fail_count++;
         $display("CHECK FAILED at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   task automatic start_test(input string name);
      cur_test       = name;
      fails_at_start = fail_count;
   endtask

   task automatic end_test();
      test_count++;
      if (fail_count == fails_at_start) begin
         $display("test %s: ok", cur_test);
      end else begin
         test_fail_count++;
         $display("test %s: %0d mismatches", cur_test, fail_count - fails_at_start);
      end
   endtask

   // --------------------
   // table rows
   // --------------------
   task automatic drive_row(input int i);
      vec_t        v;
      mem_req_t    rq;
      mem_req_t    wq;
      mem_req_w_t  wd;
      axi_r_t      rr;
      axi_b_t      bb;
      logic [31:0] r;
      v            = VECS[i];
      r            = lcg_next();
      rq.addr      = {r[7:0], lcg_next()};
      rq.len       = r[15:8];
      rq.size      = r[18:16];
      rq.id        = r[23:20];
      rq.command   = v.rd_cmd;
      rq.atomic    = v.rd_op;
      rq.cacheable = v.rd_cacheable;
      r            = lcg_next();
      wq.addr      = {r[7:0], lcg_next()};
      wq.len       = r[15:8];
      wq.size      = r[18:16];
      wq.id        = r[23:20];
      wq.command   = v.wr_cmd;
      wq.atomic    = v.wr_op;
      wq.cacheable = v.wr_cacheable;
      wd.data      = {lcg_next(), lcg_next()};
      wd.be        = r[31:24];
      wd.last      = r[19];
      rr.data      = {lcg_next(), lcg_next()};
      rr.id        = r[27:24];
      rr.resp      = v.r_resp;
      rr.last      = r[28];
      bb.id        = r[31:28];
      bb.resp      = v.b_resp;
      rd_req_i        <= rq;
      wr_req_i        <= wq;
      wr_data_i       <= wd;
      r_i             <= rr;
      b_i             <= bb;
      // handshake levels walk through the row index bits
      rd_req_valid_i  <= ~i[1];
      wr_req_valid_i  <= ~i[0];
      wr_data_valid_i <= i[1];
      r_valid_i       <= ~i[2];
      b_valid_i       <= i[2];
      ar_ready_i      <= i[0];
      aw_ready_i      <= i[1];
      w_ready_i       <= i[2];
      rd_rsp_ready_i  <= i[3];
      wr_rsp_ready_i  <= ~i[3];
   endtask

   task automatic check_row(input int i, input int group);
      vec_t        v;
      axi_ar_t     exp_ar;
      axi_aw_t     exp_aw;
      axi_w_t      exp_w;
      mem_resp_r_t exp_rr;
      mem_resp_w_t exp_wr;
      v = VECS[i];
      if (group == 0) begin
         exp_ar = '{rd_req_i.addr, rd_req_i.len, rd_req_i.size, rd_req_i.id, v.exp_ar_lock,
                    AXI_BURST_INCR, AXI_CACHE_BUFFERABLE, v.rd_cacheable};
         check_value("ar_o", 128'(exp_ar), 128'(ar_o));
         check_value("ar_valid_o", 128'(rd_req_valid_i), 128'(ar_valid_o));
         check_value("rd_req_ready_o", 128'(ar_ready_i), 128'(rd_req_ready_o));
      end else if (group == 1) begin
         exp_aw = '{wr_req_i.addr, wr_req_i.len, wr_req_i.size, wr_req_i.id, v.exp_aw_lock,
                    AXI_BURST_INCR, AXI_CACHE_BUFFERABLE, v.wr_cacheable, v.exp_atop};
         exp_w  = '{wr_data_i.data, wr_data_i.be, wr_data_i.last, v.wr_cacheable};
         check_value("aw_o", 128'(exp_aw), 128'(aw_o));
         check_value("w_o", 128'(exp_w), 128'(w_o));
         check_value("aw_valid_o", 128'(wr_req_valid_i), 128'(aw_valid_o));
         check_value("wr_req_ready_o", 128'(aw_ready_i), 128'(wr_req_ready_o));
         check_value("w_valid_o", 128'(wr_data_valid_i), 128'(w_valid_o));
         check_value("wr_data_ready_o", 128'(w_ready_i), 128'(wr_data_ready_o));
      end else begin
         exp_rr = '{r_i.data, r_i.last, r_i.id, v.exp_rd_err};
         exp_wr = '{v.exp_wr_err, b_i.id, v.exp_is_atomic};
         check_value("rd_rsp_o", 128'(exp_rr), 128'(rd_rsp_o));
         check_value("wr_rsp_o", 128'(exp_wr), 128'(wr_rsp_o));
         check_value("rd_rsp_valid_o", 128'(r_valid_i), 128'(rd_rsp_valid_o));
         check_value("r_ready_o", 128'(rd_rsp_ready_i), 128'(r_ready_o));
         check_value("wr_rsp_valid_o", 128'(b_valid_i), 128'(wr_rsp_valid_o));
         check_value("b_ready_o", 128'(wr_rsp_ready_i), 128'(b_ready_o));
      end
   endtask

   // one row per cycle, each checked on the following edge
   task automatic run_table(input int group);
      for (int i = 0; i < NUM_VECS; i++) begin
         @(posedge clk_i);
         if (i > 0) begin
            check_row(i - 1, group);
         end
         drive_row(i);
      end
      @(posedge clk_i);
      check_row(NUM_VECS - 1, group);
   endtask

   // --------------------
   // arbiter
   // --------------------
   function automatic mem_port_req_t random_port_req(input logic [MEM_ID_W-1:0] src);
      mem_port_req_t p;
      logic [31:0]   r;
      r        = lcg_next();
      p.addr   = {r[7:0], lcg_next()};
      p.wrn    = ~src[0];
      p.id     = r[11:8];
      p.src_id = src;
      p.data   = {lcg_next(), lcg_next()};
      p.strb   = r[23:16];
      p.amo    = r[24];
      p.amo_op = mem_atomic_e'(r[31:28] % 4'd11);
      return p;
   endfunction

   task automatic arb_cycle(input logic rv, input logic wv, input logic mr);
      logic exp_rd;
      logic exp_wr;
      @(posedge clk_i);
      rd_valid_i    <= rv;
      wr_valid_i    <= wv;
      mem_ready_i   <= mr;
      rd_port_req_i <= random_port_req(4'd0);
      wr_port_req_i <= random_port_req(4'd1);
      @(negedge clk_i);
      // favored source wins a tie, a lone valid source always wins
      exp_rd = rd_valid_i && (!wr_valid_i || !ref_prio);
      exp_wr = wr_valid_i && !exp_rd;
      check_value("rd_ready_o", 128'(exp_rd & mem_ready_i), 128'(rd_ready_o));
      check_value("wr_ready_o", 128'(exp_wr & mem_ready_i), 128'(wr_ready_o));
      check_value("mem_valid_o", 128'(exp_rd | exp_wr), 128'(mem_valid_o));
      if (exp_rd) begin
         check_value("mem_req_o", 128'(rd_port_req_i), 128'(mem_req_o));
      end else if (exp_wr) begin
         check_value("mem_req_o", 128'(wr_port_req_i), 128'(mem_req_o));
      end
      // pointer turns to the loser on the next edge
      if ((exp_rd || exp_wr) && mem_ready_i) begin
         ref_prio = exp_rd;
      end
      // transfers the port actually took
      if (mem_valid_o && mem_ready_i) begin
         accepted++;
      end
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial begin
      logic [31:0] r;
      lcg_state       = 32'h1c6b;
      check_count     = 0;
      fail_count      = 0;
      test_count      = 0;
      test_fail_count = 0;
      accepted        = 0;
      ref_prio        = 1'b0;
      reset_i         = 1'b1;
      rd_req_valid_i  = 1'b0;
      wr_req_valid_i  = 1'b0;
      wr_data_valid_i = 1'b0;
      rd_req_i        = '0;
      wr_req_i        = '0;
      wr_data_i       = '0;
      ar_ready_i      = 1'b0;
      aw_ready_i      = 1'b0;
      w_ready_i       = 1'b0;
      r_valid_i       = 1'b0;
      r_i             = '0;
      b_valid_i       = 1'b0;
      b_i             = '0;
      rd_rsp_ready_i  = 1'b0;
      wr_rsp_ready_i  = 1'b0;
      rd_valid_i      = 1'b0;
      wr_valid_i      = 1'b0;
      rd_port_req_i   = '0;
      wr_port_req_i   = '0;
      mem_ready_i     = 1'b0;
      repeat (5) @(posedge clk_i);
      reset_i <= 1'b0;

      start_test("read encoding");
      run_table(0);
      end_test();
      start_test("write encoding");
      run_table(1);
      end_test();
      start_test("response decoding");
      run_table(2);
      end_test();

      start_test("arbiter alternation");
      for (int k = 0; k < 6; k++) begin
         arb_cycle(1'b1, 1'b1, 1'b1);
      end
      end_test();

      start_test("back-pressure and single source");
      arb_cycle(1'b1, 1'b1, 1'b0);
      arb_cycle(1'b1, 1'b1, 1'b0);
      arb_cycle(1'b1, 1'b1, 1'b0);
      arb_cycle(1'b1, 1'b1, 1'b1);
      arb_cycle(1'b1, 1'b0, 1'b1);
      arb_cycle(1'b0, 1'b1, 1'b1);
      arb_cycle(1'b0, 1'b1, 1'b1);
      arb_cycle(1'b0, 1'b0, 1'b1);
      end_test();

      start_test("random traffic");
      accepted = 0;
      for (int k = 0; k < RAND_CYCLES; k++) begin
         r = lcg_next();
         arb_cycle(r[0], r[1], r[2] | r[3]);
      end
      if (accepted == 0) begin
         fail_count++;
         $display("random traffic produced no accepted transfer");
      end
      end_test();

      $display("tests %0d, failed tests %0d, checks %0d, mismatches %0d",
               test_count, test_fail_count, check_count, fail_count);
      if (fail_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: files.f
+incdir+bench
hdl/mem_adapter_pkg.sv
hdl/axi_req_encoder.sv
hdl/axi_resp_decoder.sv
hdl/mem_port_arbiter.sv
hdl/mem_adapter_top.sv
bench/tb_mem_adapter.sv

// File: hdl/axi_req_encoder.sv
// cache read, write and write data requests encoded onto AXI AR, AW and W
`timescale 1ns/10ps

module axi_req_encoder
   import mem_adapter_pkg::*;
(
   input  logic       rd_req_valid_i,
   input  mem_req_t   rd_req_i,
   output logic       rd_req_ready_o,

   input  logic       wr_req_valid_i,
   input  mem_req_t   wr_req_i,
   output logic       wr_req_ready_o,

   input  logic       wr_data_valid_i,
   input  mem_req_w_t wr_data_i,
   output logic       wr_data_ready_o,

   output logic       ar_valid_o,
   output axi_ar_t    ar_o,
   input  logic       ar_ready_i,

   output logic       aw_valid_o,
   output axi_aw_t    aw_o,
   input  logic       aw_ready_i,

   output logic       w_valid_o,
   output axi_w_t     w_o,
   input  logic       w_ready_i
);

   logic rd_is_amo;
   logic wr_is_amo;

   assign rd_is_amo = (rd_req_i.command == MEM_ATOMIC);
   assign wr_is_amo = (wr_req_i.command == MEM_ATOMIC);

   // handshakes go straight through
   assign ar_valid_o      = rd_req_valid_i;
   assign rd_req_ready_o  = ar_ready_i;
   assign aw_valid_o      = wr_req_valid_i;
   assign wr_req_ready_o  = aw_ready_i;
   assign w_valid_o       = wr_data_valid_i;
   assign wr_data_ready_o = w_ready_i;

   // --------------------
   // read address
   // --------------------
   always_comb begin
      ar_o.addr  = rd_req_i.addr;
      ar_o.len   = rd_req_i.len;
      ar_o.size  = rd_req_i.size;
      ar_o.id    = rd_req_i.id;
      // exclusive load
      ar_o.lock  = rd_is_amo && (rd_req_i.atomic == MEM_ATOMIC_LDEX);
      ar_o.burst = AXI_BURST_INCR;
      ar_o.cache = AXI_CACHE_BUFFERABLE;
      ar_o.user  = rd_req_i.cacheable;
   end

   // --------------------
   // write address
   // --------------------
   always_comb begin
      aw_o.addr  = wr_req_i.addr;
      aw_o.len   = wr_req_i.len;
      aw_o.size  = wr_req_i.size;
      aw_o.id    = wr_req_i.id;
      aw_o.lock  = wr_is_amo && (wr_req_i.atomic == MEM_ATOMIC_STEX);
      aw_o.burst = AXI_BURST_INCR;
      aw_o.cache = AXI_CACHE_BUFFERABLE;
      aw_o.user  = wr_req_i.cacheable;
      // atop type, then a zero bit, then the low bits of the op code
      if (!wr_is_amo) begin
         aw_o.atop = {AXI_ATOP_NONE, 1'b0, 3'b000};
      end else if (wr_req_i.atomic == MEM_ATOMIC_SWAP) begin
         aw_o.atop = {AXI_ATOP_SWAP, 1'b0, wr_req_i.atomic[2:0]};
      end else begin
         aw_o.atop = {AXI_ATOP_STORE, 1'b0, wr_req_i.atomic[2:0]};
      end
   end

   // --------------------
   // write data
   // --------------------
   always_comb begin
      w_o.data = wr_data_i.data;
      w_o.strb = wr_data_i.be;
      w_o.last = wr_data_i.last;
      // W has no attributes of its own, so it follows the current AW
      w_o.user = wr_req_i.cacheable;
   end

   // cache protocol and atop/lock exclusion
   always_comb begin
      if (rd_req_valid_i) begin
         assert final (rd_req_i.command != MEM_WRITE)
            else $error("write command presented on the read request channel");
      end
      if (aw_valid_o) begin
         assert final (!(aw_o.lock && aw_o.atop[5:4] == AXI_ATOP_SWAP))
            else $error("exclusive AW lock combined with swap atop");
      end
   end

endmodule

// File: hdl/axi_resp_decoder.sv
// AXI R and B responses decoded into cache read and write responses
`timescale 1ns/10ps

module axi_resp_decoder
   import mem_adapter_pkg::*;
(
   input  logic        r_valid_i,
   input  axi_r_t      r_i,
   output logic        r_ready_o,

   input  logic        b_valid_i,
   input  axi_b_t      b_i,
   output logic        b_ready_o,

   output logic        rd_rsp_valid_o,
   output mem_resp_r_t rd_rsp_o,
   input  logic        rd_rsp_ready_i,

   output logic        wr_rsp_valid_o,
   output mem_resp_w_t wr_rsp_o,
   input  logic        wr_rsp_ready_i
);

   // handshakes
   assign rd_rsp_valid_o = r_valid_i;
   assign r_ready_o      = rd_rsp_ready_i;
   assign wr_rsp_valid_o = b_valid_i;
   assign b_ready_o      = wr_rsp_ready_i;

   // --------------------
   // read response
   // --------------------
   always_comb begin
      rd_rsp_o.data  = r_i.data;
      rd_rsp_o.last  = r_i.last;
      rd_rsp_o.id    = r_i.id;
      // slverr and decerr both count as errors
      rd_rsp_o.error = !(r_i.resp == AXI_RESP_OKAY || r_i.resp == AXI_RESP_EXOKAY);
   end

   // --------------------
   // write response
   // --------------------
   always_comb begin
      wr_rsp_o.error     = !(b_i.resp == AXI_RESP_OKAY || b_i.resp == AXI_RESP_EXOKAY);
      wr_rsp_o.id        = b_i.id;
      // exokay marks a successful exclusive or atomic
      wr_rsp_o.is_atomic = (b_i.resp == AXI_RESP_EXOKAY);
   end

endmodule

// File: hdl/mem_adapter_pkg.sv
// widths, encodings and packed structs for the cache memory adapter
package mem_adapter_pkg;

   // --------------------
   // widths
   // --------------------
   localparam int unsigned ADDR_W     = 40;
   localparam int unsigned MEM_ID_W   = 4;
   localparam int unsigned MEM_DATA_W = 64;
   localparam int unsigned MEM_STRB_W = MEM_DATA_W / 8;
   localparam int unsigned LEN_W      = 8;
   localparam int unsigned SIZE_W     = 3;

   // --------------------
   // fixed AXI attributes
   // --------------------
   localparam logic [1:0] AXI_BURST_INCR       = 2'd1;
   localparam logic [3:0] AXI_CACHE_BUFFERABLE = 4'd1;

   // upper two bits of atop
   localparam logic [1:0] AXI_ATOP_NONE  = 2'd0;
   localparam logic [1:0] AXI_ATOP_STORE = 2'd1;
   localparam logic [1:0] AXI_ATOP_SWAP  = 2'd3;

   // --------------------
   // encodings
   // --------------------
   typedef enum logic [1:0] {
      MEM_READ   = 2'd0,
      MEM_WRITE  = 2'd1,
      MEM_ATOMIC = 2'd2
   } mem_command_e;

   typedef enum logic [3:0] {
      MEM_ATOMIC_ADD  = 4'd0,
      MEM_ATOMIC_CLR  = 4'd1,
      MEM_ATOMIC_SET  = 4'd2,
      MEM_ATOMIC_EOR  = 4'd3,
      MEM_ATOMIC_SMAX = 4'd4,
      MEM_ATOMIC_SMIN = 4'd5,
      MEM_ATOMIC_UMAX = 4'd6,
      MEM_ATOMIC_UMIN = 4'd7,
      MEM_ATOMIC_SWAP = 4'd8,
      MEM_ATOMIC_LDEX = 4'd9,
      MEM_ATOMIC_STEX = 4'd10
   } mem_atomic_e;

   typedef enum logic [1:0] {
      AXI_RESP_OKAY   = 2'd0,
      AXI_RESP_EXOKAY = 2'd1,
      AXI_RESP_SLVERR = 2'd2,
      AXI_RESP_DECERR = 2'd3
   } axi_resp_e;

   // --------------------
   // cache side
   // --------------------
   typedef struct packed {
      logic [ADDR_W-1:0]   addr;
      logic [LEN_W-1:0]    len;
      logic [SIZE_W-1:0]   size;
      logic [MEM_ID_W-1:0] id;
      mem_command_e        command;
      mem_atomic_e         atomic;
      logic                cacheable;
   } mem_req_t;

   typedef struct packed {
      logic [MEM_DATA_W-1:0] data;
      logic [MEM_STRB_W-1:0] be;
      logic                  last;
   } mem_req_w_t;

   typedef struct packed {
      logic [MEM_DATA_W-1:0] data;
      logic                  last;
      logic [MEM_ID_W-1:0]   id;
      logic                  error;
   } mem_resp_r_t;

   typedef struct packed {
      logic                error;
      logic [MEM_ID_W-1:0] id;
      logic                is_atomic;
   } mem_resp_w_t;

   // --------------------
   // AXI side
   // --------------------
   typedef struct packed {
      logic [ADDR_W-1:0]   addr;
      logic [LEN_W-1:0]    len;
      logic [SIZE_W-1:0]   size;
      logic [MEM_ID_W-1:0] id;
      logic                lock;
      logic [1:0]          burst;
      logic [3:0]          cache;
      logic                user;
   } axi_ar_t;

   typedef struct packed {
      logic [ADDR_W-1:0]   addr;
      logic [LEN_W-1:0]    len;
      logic [SIZE_W-1:0]   size;
      logic [MEM_ID_W-1:0] id;
      logic                lock;
      logic [1:0]          burst;
      logic [3:0]          cache;
      logic                user;
      logic [5:0]          atop;
   } axi_aw_t;

   typedef struct packed {
      logic [MEM_DATA_W-1:0] data;
      logic [MEM_STRB_W-1:0] strb;
      logic                  last;
      logic                  user;
   } axi_w_t;

   typedef struct packed {
      logic [MEM_DATA_W-1:0] data;
      logic [MEM_ID_W-1:0]   id;
      axi_resp_e             resp;
      logic                  last;
   } axi_r_t;

   typedef struct packed {
      logic [MEM_ID_W-1:0] id;
      axi_resp_e           resp;
   } axi_b_t;

   // --------------------
   // memory model port
   // --------------------
   typedef struct packed {
      logic [ADDR_W-1:0]     addr;
      logic                  wrn;     // 0 for write
      logic [MEM_ID_W-1:0]   id;
      logic [MEM_ID_W-1:0]   src_id;
      logic [MEM_DATA_W-1:0] data;
      logic [MEM_STRB_W-1:0] strb;
      logic                  amo;
      mem_atomic_e           amo_op;
   } mem_port_req_t;

   localparam int unsigned MEM_PORT_REQ_W = $bits(mem_port_req_t);

endpackage

// File: hdl/mem_adapter_top.sv
// adapter top joining the AXI request encoder, response decoder and port arbiter
`timescale 1ns/10ps

module mem_adapter_top
   import mem_adapter_pkg::*;
(
   input  logic          clk_i,
   input  logic          reset_i,

   // --------------------
   // cache requests
   // --------------------
   input  logic          rd_req_valid_i,
   input  mem_req_t      rd_req_i,
   output logic          rd_req_ready_o,
   input  logic          wr_req_valid_i,
   input  mem_req_t      wr_req_i,
   output logic          wr_req_ready_o,
   input  logic          wr_data_valid_i,
   input  mem_req_w_t    wr_data_i,
   output logic          wr_data_ready_o,

   // --------------------
   // AXI
   // --------------------
   output logic          ar_valid_o,
   output axi_ar_t       ar_o,
   input  logic          ar_ready_i,
   output logic          aw_valid_o,
   output axi_aw_t       aw_o,
   input  logic          aw_ready_i,
   output logic          w_valid_o,
   output axi_w_t        w_o,
   input  logic          w_ready_i,
   input  logic          r_valid_i,
   input  axi_r_t        r_i,
   output logic          r_ready_o,
   input  logic          b_valid_i,
   input  axi_b_t        b_i,
   output logic          b_ready_o,

   // --------------------
   // cache responses
   // --------------------
   output logic          rd_rsp_valid_o,
   output mem_resp_r_t   rd_rsp_o,
   input  logic          rd_rsp_ready_i,
   output logic          wr_rsp_valid_o,
   output mem_resp_w_t   wr_rsp_o,
   input  logic          wr_rsp_ready_i,

   // --------------------
   // memory model sources and port
   // --------------------
   // payloads renamed here to keep clear of the cache request ports
   input  logic          rd_valid_i,
   input  mem_port_req_t rd_port_req_i,
   output logic          rd_ready_o,
   input  logic          wr_valid_i,
   input  mem_port_req_t wr_port_req_i,
   output logic          wr_ready_o,
   output logic          mem_valid_o,
   output mem_port_req_t mem_req_o,
   input  logic          mem_ready_i
);

   axi_req_encoder u_req_enc (
      .rd_req_valid_i  (rd_req_valid_i),
      .rd_req_i        (rd_req_i),
      .rd_req_ready_o  (rd_req_ready_o),
      .wr_req_valid_i  (wr_req_valid_i),
      .wr_req_i        (wr_req_i),
      .wr_req_ready_o  (wr_req_ready_o),
      .wr_data_valid_i (wr_data_valid_i),
      .wr_data_i       (wr_data_i),
      .wr_data_ready_o (wr_data_ready_o),
      .ar_valid_o      (ar_valid_o),
      .ar_o            (ar_o),
      .ar_ready_i      (ar_ready_i),
      .aw_valid_o      (aw_valid_o),
      .aw_o            (aw_o),
      .aw_ready_i      (aw_ready_i),
      .w_valid_o       (w_valid_o),
      .w_o             (w_o),
      .w_ready_i       (w_ready_i)
   );

   axi_resp_decoder u_resp_dec (
      .r_valid_i      (r_valid_i),
      .r_i            (r_i),
      .r_ready_o      (r_ready_o),
      .b_valid_i      (b_valid_i),
      .b_i            (b_i),
      .b_ready_o      (b_ready_o),
      .rd_rsp_valid_o (rd_rsp_valid_o),
      .rd_rsp_o       (rd_rsp_o),
      .rd_rsp_ready_i (rd_rsp_ready_i),
      .wr_rsp_valid_o (wr_rsp_valid_o),
      .wr_rsp_o       (wr_rsp_o),
      .wr_rsp_ready_i (wr_rsp_ready_i)
   );

   mem_port_arbiter u_port_arb (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .rd_valid_i  (rd_valid_i),
      .rd_req_i    (rd_port_req_i),
      .rd_ready_o  (rd_ready_o),
      .wr_valid_i  (wr_valid_i),
      .wr_req_i    (wr_port_req_i),
      .wr_ready_o  (wr_ready_o),
      .mem_valid_o (mem_valid_o),
      .mem_req_o   (mem_req_o),
      .mem_ready_i (mem_ready_i)
   );

endmodule

// File: hdl/mem_port_arbiter.sv
// two-way round-robin arbiter merging read and write sources onto one memory port
`timescale 1ns/10ps

module mem_port_arbiter
   import mem_adapter_pkg::*;
(
   input  logic          clk_i,
   input  logic          reset_i,

   // source 0
   input  logic          rd_valid_i,
   input  mem_port_req_t rd_req_i,
   output logic          rd_ready_o,

   // source 1
   input  logic          wr_valid_i,
   input  mem_port_req_t wr_req_i,
   output logic          wr_ready_o,

   output logic          mem_valid_o,
   output mem_port_req_t mem_req_o,
   input  logic          mem_ready_i
);

   // 0 favors read, 1 favors write
   logic       prio_q;
   logic [1:0] gnt;
   logic       accept;

   // --------------------
   // grant
   // --------------------
   always_comb begin
      gnt = 2'b00;
      if (prio_q == 1'b0) begin
         if (rd_valid_i) begin
            gnt = 2'b01;
         end else if (wr_valid_i) begin
            gnt = 2'b10;
         end
      end else begin
         if (wr_valid_i) begin
            gnt = 2'b10;
         end else if (rd_valid_i) begin
            gnt = 2'b01;
         end
      end
   end

   assign rd_ready_o  = gnt[0] & mem_ready_i;
   assign wr_ready_o  = gnt[1] & mem_ready_i;
   assign mem_valid_o = |gnt;
   assign accept      = mem_valid_o & mem_ready_i;

   // one-hot AND-OR select of the payload
   assign mem_req_o = mem_port_req_t'(({MEM_PORT_REQ_W{gnt[0]}} & rd_req_i) |
                                      ({MEM_PORT_REQ_W{gnt[1]}} & wr_req_i));

   // --------------------
   // priority pointer
   // --------------------
   // moves past the winner once the port takes the transfer
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         prio_q <= 1'b0;
      end else if (accept) begin
         prio_q <= gnt[0];
      end
   end

   // --------------------
   // checks
   // --------------------
   a_gnt_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(gnt))
      else $error("arbiter grant is not one-hot");

   a_gnt_valid : assert property (@(posedge clk_i) disable iff (reset_i)
      (gnt & ~{wr_valid_i, rd_valid_i}) == 2'b00)
      else $error("grant given to a source without valid");

   // a stalled port must not rotate the priority
   a_prio_hold : assert property (@(posedge clk_i) disable iff (reset_i)
      !mem_ready_i |=> $stable(prio_q))
      else $error("priority pointer moved while the memory port stalled");

endmodule
